//--- Makefile
# Verilator build and run of the RPU partition testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, pass on TEST PASSED"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_rpu_partition -Mdir obj_dir -o sim_rpu
	@out="$$(./obj_dir/sim_rpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

//--- list.f
+incdir+source
source/rpu_pkg.sv
source/boundary_slice.sv
source/pmem.sv
source/desc_forward.sv
source/rpu_status.sv
source/rpu_core.sv
source/rpu_partition.sv
sim/tb_rpu_partition.sv

//--- sim/tb_rpu_partition.sv
// Self-checking testbench for the RPU partition, run as top level through list.f
`timescale 1ns/1ps
`include "rpu_config.svh"

module tb_rpu_partition import rpu_pkg::*; ();

  localparam int BC_BASE    = `RPU_PMEM_LINES - `RPU_BC_REGION_LINES;
  localparam int TEST_LINES = 32;
  localparam int N_WR       = 64;
  localparam int N_RD       = 64;
  localparam int N_DESC     = 32;
  localparam int N_BCIN     = 32;
  localparam int N_RD2      = 16;
  // A region write counts as five beats for the write and up to four messages
  localparam int STIM_BEATS = (TEST_LINES + N_WR) * 5 + N_RD + N_DESC + N_BCIN + N_RD2 + 8;
  localparam int TIMEOUT_NS = STIM_BEATS * 200 + 100000;

  logic         clk;
  logic         rst;
  logic         core_reset;
  logic         dma_cmd_wr_en;
  dma_addr_t    dma_cmd_wr_addr;
  data_t        dma_cmd_wr_data;
  strb_t        dma_cmd_wr_strb;
  logic         dma_cmd_wr_ready;
  logic         dma_cmd_rd_en;
  dma_addr_t    dma_cmd_rd_addr;
  logic         dma_cmd_rd_ready;
  logic         dma_rd_resp_valid;
  data_t        dma_rd_resp_data;
  logic         dma_rd_resp_ready;
  desc_t        in_desc;
  logic         in_desc_valid;
  logic         in_desc_taken;
  desc_t        out_desc;
  logic         out_desc_valid;
  logic         out_desc_ready;
  bc_msg_t      bc_msg_in;
  logic         bc_msg_in_valid;
  bc_msg_t      bc_msg_out;
  logic         bc_msg_out_valid;
  logic         bc_msg_out_ready;
  logic [31:0]  intercon_status_data;
  status_addr_t intercon_status_addr;
  logic [31:0]  rpu_status_data;
  status_addr_t rpu_status_addr;

  // Reference model state
  data_t       mem_model [`RPU_PMEM_LINES];
  logic [31:0] cnt_model [`RPU_STATUS_SLOTS];
  port_t       route_model;
  data_t       exp_rd [$];
  desc_t       exp_desc [$];
  bc_msg_t     exp_bc [$];
  int          checks;
  int          mismatch_errors;
  int          protocol_errors;

  rpu_partition rpu_partition_inst (.*);

  // 100 ns period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////////////////////////

  // Byte-strobed merge into a line
  function automatic data_t merge_line(data_t old_line, data_t new_data, strb_t strb);
    data_t res;
    res = old_line;
    for (int i = 0; i < `RPU_STRB_WIDTH; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_data[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Forwarded descriptor with only the port replaced
  function automatic desc_t forward_model(desc_t d, port_t r);
    desc_t res;
    res      = d;
    res.port = r;
    return res;
  endfunction

  // Slot 0 holds the route and slots 1 to 5 the counters
  function automatic logic [31:0] status_model(status_addr_t a);
    if (a == status_addr_t'(`RPU_ST_ROUTE)) begin
      return {28'd0, route_model};
    end
    return cnt_model[a];
  endfunction

  // Half the test lines sit low and half at the top of the region
  function automatic int test_line(int idx);
    if (idx < TEST_LINES / 2) begin
      return 100 + idx;
    end
    return `RPU_PMEM_LINES - TEST_LINES + idx;
  endfunction

  // Bits outside the line select carry noise
  function automatic dma_addr_t make_addr(int line);
    return {12'($urandom), 10'(line), 4'($urandom)};
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus tasks entered and left on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic dma_write(input int line, input data_t data, input strb_t strb);
    bc_msg_t msg;
    logic    accepted;
    dma_cmd_wr_addr = make_addr(line);
    dma_cmd_wr_data = data;
    dma_cmd_wr_strb = strb;
    dma_cmd_wr_en   = 1'b1;
    mem_model[line] = merge_line(mem_model[line], data, strb);
    cnt_model[`RPU_ST_WR] += 32'd1;
    // One message per strobed word lane in lane order
    if (line >= BC_BASE) begin
      for (int k = 0; k < 4; k++) begin
        if (strb[4*k +: 4] != 4'h0) begin
          msg.data  = data[32*k +: 32];
          msg.strb  = strb[4*k +: 4];
          msg.waddr = 11'((line - BC_BASE) * 4 + k);
          exp_bc.push_back(msg);
          cnt_model[`RPU_ST_BC_OUT] += 32'd1;
        end
      end
    end
    // Registered ready seen at the falling edge decides the coming rising edge
    do begin
      accepted = (dma_cmd_wr_ready === 1'b1);
      @(negedge clk);
    end while (!accepted);
    dma_cmd_wr_en = 1'b0;
  endtask

  task automatic dma_read(input int line);
    logic accepted;
    dma_cmd_rd_addr = make_addr(line);
    dma_cmd_rd_en   = 1'b1;
    exp_rd.push_back(mem_model[line]);
    cnt_model[`RPU_ST_RD] += 32'd1;
    do begin
      accepted = (dma_cmd_rd_ready === 1'b1);
      @(negedge clk);
    end while (!accepted);
    dma_cmd_rd_en = 1'b0;
  endtask

  // Level valid held until the taken pulse
  task automatic send_desc(input desc_t d);
    logic accepted;
    in_desc       = d;
    in_desc_valid = 1'b1;
    exp_desc.push_back(forward_model(d, route_model));
    cnt_model[`RPU_ST_FWD] += 32'd1;
    do begin
      accepted = (in_desc_taken === 1'b1);
      @(negedge clk);
    end while (!accepted);
    in_desc_valid = 1'b0;
  endtask

  // One-cycle strobe written straight into the region
  task automatic broadcast_in(input int line, input int lane, input logic [31:0] data,
                              input logic [3:0] strb);
    bc_msg_in.data  = data;
    bc_msg_in.strb  = strb;
    bc_msg_in.waddr = 11'((line - BC_BASE) * 4 + lane);
    bc_msg_in_valid = 1'b1;
    mem_model[line] = merge_line(mem_model[line], {4{data}}, strb_t'(strb) << (4 * lane));
    cnt_model[`RPU_ST_BC_IN] += 32'd1;
    @(negedge clk);
    bc_msg_in_valid = 1'b0;
  endtask

  task automatic set_route(input port_t r);
    intercon_status_addr = status_addr_t'(`RPU_ST_ROUTE);
    intercon_status_data = {28'($urandom), r};
    route_model          = r;
    @(negedge clk);
    // Slot 7 is ignored by the core
    intercon_status_addr = 3'd7;
    intercon_status_data = '0;
    repeat (4) @(negedge clk);
  endtask

  // Wait for all expected beats and let counters settle
  task automatic wait_idle();
    while (exp_rd.size() != 0 || exp_desc.size() != 0 || exp_bc.size() != 0) begin
      @(negedge clk);
    end
    repeat (20) @(negedge clk);
  endtask

  // Addresses must step by one and each slot must match the model
  task automatic check_status();
    logic [31:0]  exp;
    status_addr_t exp_addr;
    exp_addr = rpu_status_addr;
    repeat (`RPU_STATUS_SLOTS) begin
      @(negedge clk);
      exp_addr = exp_addr + 1'b1;
      exp      = status_model(exp_addr);
      checks++;
      if (rpu_status_addr !== exp_addr || rpu_status_data !== exp) begin
        mismatch_errors++;
        $display("[ERROR] %0d ns: status slot %0d reads %h, expected slot %0d reads %h",
                 $time, rpu_status_addr, rpu_status_data, exp_addr, exp);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Output compare and back-pressure
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare_outputs
    data_t   exp_data;
    desc_t   exp_d;
    bc_msg_t exp_m;
    // Roughly three cycles in four ready
    dma_rd_resp_ready = ($urandom_range(0, 3) != 0);
    out_desc_ready    = ($urandom_range(0, 3) != 0);
    bc_msg_out_ready  = ($urandom_range(0, 3) != 0);
    // Beats that move at the coming rising edge
    if (dma_rd_resp_valid === 1'b1 && dma_rd_resp_ready) begin
      if (exp_rd.size() == 0) begin
        protocol_errors++;
        $display("Read response at %0d ns with no read outstanding", $time);
      end else begin
        exp_data = exp_rd.pop_front();
        checks++;
        if (dma_rd_resp_data !== exp_data) begin
          mismatch_errors++;
          $display("[ERROR] %0d ns: read data %h, expected %h", $time,
                   dma_rd_resp_data, exp_data);
        end
      end
    end
    if (out_desc_valid === 1'b1 && out_desc_ready) begin
      if (exp_desc.size() == 0) begin
        protocol_errors++;
        $display("Descriptor left at %0d ns with none sent", $time);
      end else begin
        exp_d = exp_desc.pop_front();
        checks++;
        if (out_desc !== exp_d) begin
          mismatch_errors++;
          $display("[ERROR] %0d ns: out descriptor %h, expected %h", $time, out_desc, exp_d);
        end
      end
    end
    if (bc_msg_out_valid === 1'b1 && bc_msg_out_ready) begin
      if (exp_bc.size() == 0) begin
        protocol_errors++;
        $display("Broadcast message at %0d ns that no region write produced", $time);
      end else begin
        exp_m = exp_bc.pop_front();
        checks++;
        if (bc_msg_out !== exp_m) begin
          mismatch_errors++;
          $display("[ERROR] %0d ns: broadcast %h, expected %h", $time, bc_msg_out, exp_m);
        end
      end
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout at %0d ns with %0d reads, %0d descriptors, %0d broadcasts outstanding",
             $time, exp_rd.size(), exp_desc.size(), exp_bc.size());
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h46102e3f));
    rst = 1'b1;
    core_reset = 1'b0;
    dma_cmd_wr_en = 1'b0;
    dma_cmd_wr_addr = '0;
    dma_cmd_wr_data = '0;
    dma_cmd_wr_strb = '0;
    dma_cmd_rd_en = 1'b0;
    dma_cmd_rd_addr = '0;
    dma_rd_resp_ready = 1'b1;
    in_desc = '0;
    in_desc_valid = 1'b0;
    out_desc_ready = 1'b1;
    bc_msg_in = '0;
    bc_msg_in_valid = 1'b0;
    bc_msg_out_ready = 1'b1;
    intercon_status_data = '0;
    intercon_status_addr = 3'd7;
    route_model = '0;
    for (int i = 0; i < `RPU_STATUS_SLOTS; i++) begin
      cnt_model[i] = '0;
    end
    checks = 0;
    mismatch_errors = 0;
    protocol_errors = 0;

    // Outputs quiet at the end of reset
    repeat (10) @(posedge clk);
    @(negedge clk);
    checks++;
    if ({dma_cmd_wr_ready, dma_cmd_rd_ready, dma_rd_resp_valid, out_desc_valid,
         bc_msg_out_valid, in_desc_taken} !== 6'b0) begin
      mismatch_errors++;
      $display("[ERROR] %0d ns: valid or ready output high in reset", $time);
    end
    rst = 1'b0;
    repeat (5) @(negedge clk);
    check_status();

    // Known contents on every test line before random strobed writes
    for (int i = 0; i < TEST_LINES; i++) begin
      dma_write(test_line(i), {$urandom, $urandom, $urandom, $urandom}, '1);
    end
    repeat (N_WR) begin
      dma_write(test_line($urandom_range(0, TEST_LINES - 1)),
                {$urandom, $urandom, $urandom, $urandom}, strb_t'($urandom));
    end
    // Writes still parked in the slice land before any read
    wait_idle();
    repeat (N_RD) begin
      dma_read(test_line($urandom_range(0, TEST_LINES - 1)));
    end

    // Descriptors under a fresh route
    set_route(port_t'($urandom_range(1, 15)));
    repeat (N_DESC) begin
      send_desc(desc_t'({$urandom, $urandom}));
    end
    wait_idle();
    check_status();

    // Broadcasts in and read back of the region lines
    repeat (N_BCIN) begin
      broadcast_in(test_line($urandom_range(TEST_LINES / 2, TEST_LINES - 1)),
                   $urandom_range(0, 3), $urandom, 4'($urandom));
    end
    for (int i = 0; i < N_RD2; i++) begin
      dma_read(test_line(TEST_LINES / 2 + i));
    end
    wait_idle();
    check_status();

    // Core reset clears route and counters but keeps memory
    core_reset = 1'b1;
    repeat (2) @(negedge clk);
    core_reset = 1'b0;
    route_model = '0;
    for (int i = 0; i < `RPU_STATUS_SLOTS; i++) begin
      cnt_model[i] = '0;
    end
    repeat (10) @(negedge clk);
    check_status();
    repeat (8) begin
      dma_read(test_line($urandom_range(0, TEST_LINES - 1)));
    end
    wait_idle();
    check_status();

    $display("Summary: %0d checks, %0d mismatches, %0d protocol errors", checks,
             mismatch_errors, protocol_errors);
    if (mismatch_errors == 0 && protocol_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- source/boundary_slice.sv
// Two-entry skid register slice that carries one valid/ready stream across the partition edge
`timescale 1ns/1ps

module boundary_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     in_fire;
  logic     out_free;

  assign in_fire  = in_valid && in_ready;
  // Output register empty or draining this cycle
  assign out_free = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else if (out_free) begin
      // Skid entry goes first, input is stalled while it is full
      if (skid_valid) begin
        out_data   <= skid_data;
        out_valid  <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        out_valid <= in_fire;
        if (in_fire) begin
          out_data <= in_data;
        end
      end
      in_ready <= 1'b1;
    end else if (in_fire) begin
      // Downstream stalled, park the beat
      skid_data  <= in_data;
      skid_valid <= 1'b1;
      in_ready   <= 1'b0;
    end else begin
      in_ready <= !skid_valid;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Stalled beat stays put until taken
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- source/desc_forward.sv
// One-entry descriptor stage that replaces the port field with the route and holds on stall
`timescale 1ns/1ps

module desc_forward import rpu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  desc_t in_desc,
  input  logic  in_desc_valid,
  output logic  in_desc_taken,
  input  port_t route,
  output desc_t out_desc,
  output logic  out_desc_valid,
  input  logic  out_desc_ready,
  output logic  fwd_pulse
);

  logic  taken_q;
  desc_t fwd_desc;

  // Input valid is registered at the boundary, so it lingers a cycle after a take
  assign in_desc_taken = in_desc_valid && !taken_q
                       && (!out_desc_valid || out_desc_ready);
  assign fwd_pulse     = out_desc_valid && out_desc_ready;

  // Only the port changes
  always_comb begin
    fwd_desc      = in_desc;
    fwd_desc.port = route;
  end

  always_ff @(posedge clk) begin
    if (in_desc_taken) begin
      out_desc <= fwd_desc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_desc_valid <= 1'b0;
      taken_q        <= 1'b0;
    end else begin
      taken_q <= in_desc_taken;
      // Refill in the same cycle the held entry leaves
      if (in_desc_taken) begin
        out_desc_valid <= 1'b1;
      end else if (out_desc_ready) begin
        out_desc_valid <= 1'b0;
      end
    end
  end

endmodule

//--- source/pmem.sv
// Strobed packet memory with a DMA/broadcast write port and a held DMA read response
`timescale 1ns/1ps
`include "rpu_config.svh"

module pmem import rpu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      wr_en,
  input  dma_addr_t wr_addr,
  input  data_t     wr_data,
  input  strb_t     wr_strb,
  output logic      wr_ready,
  input  logic      bc_wr_en,
  input  bc_msg_t   bc_wr_msg,
  input  logic      rd_en,
  input  dma_addr_t rd_addr,
  output logic      rd_ready,
  output logic      resp_valid,
  output data_t     resp_data,
  input  logic      resp_ready
);

  localparam int BC_BASE = `RPU_PMEM_LINES - `RPU_BC_REGION_LINES;
  localparam int LANES   = `RPU_DATA_WIDTH / 32;

  data_t      mem [`RPU_PMEM_LINES];
  line_addr_t port_line;
  data_t      port_data;
  strb_t      port_strb;
  logic       port_en;
  logic       rd_fire;

  ////////////////////////////////////////////////////////////
  // Shared write port
  ////////////////////////////////////////////////////////////

  // Broadcast-in owns the port for its cycle
  assign wr_ready = !bc_wr_en;

  always_comb begin
    if (bc_wr_en) begin
      // Word address bits above the lane give the line offset in the region
      // Low 2 bits pick the lane
      port_line = line_addr_t'(BC_BASE)
                + line_addr_t'(bc_wr_msg.waddr[`RPU_BC_WORD_WIDTH-1:2]);
      port_data = {LANES{bc_wr_msg.data}};
      port_strb = strb_t'(bc_wr_msg.strb) << {bc_wr_msg.waddr[1:0], 2'b00};
      port_en   = 1'b1;
    end else begin
      port_line = line_of(wr_addr);
      port_data = wr_data;
      port_strb = wr_strb;
      port_en   = wr_en;
    end
  end

  // Byte lanes
  always_ff @(posedge clk) begin
    for (int i = 0; i < `RPU_STRB_WIDTH; i++) begin
      if (port_en && port_strb[i]) begin
        mem[port_line][8*i +: 8] <= port_data[8*i +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  // New command only when the response register frees up
  assign rd_ready = !resp_valid || resp_ready;
  assign rd_fire  = rd_en && rd_ready;

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      resp_data <= mem[line_of(rd_addr)];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else if (rd_fire) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  // DMA write not taken in a broadcast-in cycle and still offered after it
  a_wr_held: assert property (@(posedge clk) disable iff (rst)
    wr_en && bc_wr_en |=> wr_en && $stable(wr_addr) && $stable(wr_data)
                          && $stable(wr_strb));

endmodule

//--- source/rpu_config.svh
// Widths, memory sizes and status slot layout for the RPU, included by the package and RTL
`ifndef RPU_CONFIG_SVH
`define RPU_CONFIG_SVH

// DMA beat and memory line
`define RPU_DATA_WIDTH      128
`define RPU_STRB_WIDTH      16
`define RPU_DMA_ADDR_WIDTH  26

// Packet memory, broadcast region is the top part
`define RPU_PMEM_LINES      1024
`define RPU_BC_REGION_LINES 512
`define RPU_BC_WORD_WIDTH   11

// Status channel slots
`define RPU_STATUS_SLOTS    8
`define RPU_ST_ROUTE        0
`define RPU_ST_FWD          1
`define RPU_ST_WR           2
`define RPU_ST_RD           3
`define RPU_ST_BC_OUT       4
`define RPU_ST_BC_IN        5

`endif

//--- source/rpu_core.sv
// Stand-in RPU core with packet memory, descriptor forwarding, broadcast region and status
`timescale 1ns/1ps
`include "rpu_config.svh"

module rpu_core import rpu_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         core_reset,
  input  logic         dma_cmd_wr_en,
  input  dma_addr_t    dma_cmd_wr_addr,
  input  data_t        dma_cmd_wr_data,
  input  strb_t        dma_cmd_wr_strb,
  output logic         dma_cmd_wr_ready,
  input  logic         dma_cmd_rd_en,
  input  dma_addr_t    dma_cmd_rd_addr,
  output logic         dma_cmd_rd_ready,
  output logic         dma_rd_resp_valid,
  output data_t        dma_rd_resp_data,
  input  logic         dma_rd_resp_ready,
  input  desc_t        in_desc,
  input  logic         in_desc_valid,
  output logic         in_desc_taken,
  output desc_t        out_desc,
  output logic         out_desc_valid,
  input  logic         out_desc_ready,
  input  bc_msg_t      bc_msg_in,
  input  logic         bc_msg_in_valid,
  output bc_msg_t      bc_msg_out,
  output logic         bc_msg_out_valid,
  input  logic         bc_msg_out_ready,
  input  logic [31:0]  intercon_status_data,
  input  status_addr_t intercon_status_addr,
  output logic [31:0]  rpu_status_data,
  output status_addr_t rpu_status_addr
);

  localparam int LANES   = `RPU_DATA_WIDTH / 32;
  localparam int QW      = $clog2(LANES);
  localparam int BC_BASE = `RPU_PMEM_LINES - `RPU_BC_REGION_LINES;

  logic             core_rst;
  logic             pmem_wr_ready;
  logic             q_room;
  logic             wr_fire;
  logic             bc_pop;
  logic             in_region;
  line_addr_t       region_off;
  logic [LANES-1:0] lane_hit;
  bc_msg_t          lane_msg [LANES];
  logic [QW-1:0]    lane_slot [LANES];
  bc_msg_t          q_mem [LANES];
  logic [QW-1:0]    q_wp;
  logic [QW-1:0]    q_rp;
  logic [QW:0]      q_cnt;
  logic [QW:0]      push_n;
  port_t            route;
  logic             fwd_pulse;

  // Either reset clears control state, memory keeps contents
  assign core_rst = rst || core_reset;

  ////////////////////////////////////////////////////////////
  // Broadcast-region write decode
  ////////////////////////////////////////////////////////////

  assign in_region  = line_of(dma_cmd_wr_addr) >= line_addr_t'(BC_BASE);
  assign region_off = line_of(dma_cmd_wr_addr) - line_addr_t'(BC_BASE);
  // Write waits until the queue could take every lane
  assign q_room           = q_cnt <= {{QW{1'b0}}, bc_pop};
  assign dma_cmd_wr_ready = pmem_wr_ready && q_room;
  assign wr_fire          = dma_cmd_wr_en && dma_cmd_wr_ready;

  // Strobed lanes packed into consecutive queue slots, lane 0 first
  always_comb begin
    push_n = '0;
    for (int k = 0; k < LANES; k++) begin
      lane_hit[k]       = in_region && (|dma_cmd_wr_strb[4*k +: 4]);
      lane_msg[k].data  = dma_cmd_wr_data[32*k +: 32];
      lane_msg[k].strb  = dma_cmd_wr_strb[4*k +: 4];
      lane_msg[k].waddr = `RPU_BC_WORD_WIDTH'({region_off, QW'(k)});
      lane_slot[k]      = q_wp + push_n[QW-1:0];
      if (wr_fire && lane_hit[k]) begin
        push_n = push_n + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Broadcast out queue
  ////////////////////////////////////////////////////////////

  assign bc_msg_out       = q_mem[q_rp];
  assign bc_msg_out_valid = q_cnt != '0;
  assign bc_pop           = bc_msg_out_valid && bc_msg_out_ready;

  always_ff @(posedge clk) begin
    for (int k = 0; k < LANES; k++) begin
      if (wr_fire && lane_hit[k]) begin
        q_mem[lane_slot[k]] <= lane_msg[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (core_rst) begin
      q_wp  <= '0;
      q_rp  <= '0;
      q_cnt <= '0;
    end else begin
      q_wp  <= q_wp + push_n[QW-1:0];
      q_rp  <= q_rp + QW'(bc_pop);
      q_cnt <= q_cnt + push_n - (QW+1)'(bc_pop);
    end
  end

  ////////////////////////////////////////////////////////////
  // Submodules
  ////////////////////////////////////////////////////////////

  pmem pmem_inst (
    .clk        (clk),
    .rst        (core_rst),
    .wr_en      (dma_cmd_wr_en && q_room),
    .wr_addr    (dma_cmd_wr_addr),
    .wr_data    (dma_cmd_wr_data),
    .wr_strb    (dma_cmd_wr_strb),
    .wr_ready   (pmem_wr_ready),
    .bc_wr_en   (bc_msg_in_valid),
    .bc_wr_msg  (bc_msg_in),
    .rd_en      (dma_cmd_rd_en),
    .rd_addr    (dma_cmd_rd_addr),
    .rd_ready   (dma_cmd_rd_ready),
    .resp_valid (dma_rd_resp_valid),
    .resp_data  (dma_rd_resp_data),
    .resp_ready (dma_rd_resp_ready)
  );

  desc_forward desc_forward_inst (
    .clk            (clk),
    .rst            (core_rst),
    .in_desc        (in_desc),
    .in_desc_valid  (in_desc_valid),
    .in_desc_taken  (in_desc_taken),
    .route          (route),
    .out_desc       (out_desc),
    .out_desc_valid (out_desc_valid),
    .out_desc_ready (out_desc_ready),
    .fwd_pulse      (fwd_pulse)
  );

  rpu_status rpu_status_inst (
    .clk                  (clk),
    .rst                  (core_rst),
    .intercon_status_data (intercon_status_data),
    .intercon_status_addr (intercon_status_addr),
    .fwd_pulse            (fwd_pulse),
    .wr_pulse             (wr_fire),
    .rd_pulse             (dma_cmd_rd_en && dma_cmd_rd_ready),
    .bc_out_pulse         (bc_pop),
    .bc_in_pulse          (bc_msg_in_valid),
    .route                (route),
    .rpu_status_data      (rpu_status_data),
    .rpu_status_addr      (rpu_status_addr)
  );

endmodule

//--- source/rpu_partition.sv
// RPU partition top: boundary registers and slices around the core, instantiated by the shell
`timescale 1ns/1ps

module rpu_partition import rpu_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         core_reset,
  // DMA interface
  input  logic         dma_cmd_wr_en,
  input  dma_addr_t    dma_cmd_wr_addr,
  input  data_t        dma_cmd_wr_data,
  input  strb_t        dma_cmd_wr_strb,
  output logic         dma_cmd_wr_ready,
  input  logic         dma_cmd_rd_en,
  input  dma_addr_t    dma_cmd_rd_addr,
  output logic         dma_cmd_rd_ready,
  output logic         dma_rd_resp_valid,
  output data_t        dma_rd_resp_data,
  input  logic         dma_rd_resp_ready,
  // Descriptors
  input  desc_t        in_desc,
  input  logic         in_desc_valid,
  output logic         in_desc_taken,
  output desc_t        out_desc,
  output logic         out_desc_valid,
  input  logic         out_desc_ready,
  // Broadcast messages
  input  bc_msg_t      bc_msg_in,
  input  logic         bc_msg_in_valid,
  output bc_msg_t      bc_msg_out,
  output logic         bc_msg_out_valid,
  input  logic         bc_msg_out_ready,
  // Status channels
  input  logic [31:0]  intercon_status_data,
  input  status_addr_t intercon_status_addr,
  output logic [31:0]  rpu_status_data,
  output status_addr_t rpu_status_addr
);

  // _r after an input register or slice, _n core side before an output slice
  logic         rst_r;
  logic         core_reset_r;
  desc_t        in_desc_r;
  logic         in_desc_valid_r;
  bc_msg_t      bc_msg_in_r;
  logic         bc_msg_in_valid_r;
  logic [31:0]  intercon_status_data_r;
  status_addr_t intercon_status_addr_r;
  dma_wr_t      wr_beat;
  dma_wr_t      wr_beat_r;
  logic         wr_en_r;
  logic         wr_ready_r;
  dma_addr_t    rd_addr_r;
  logic         rd_en_r;
  logic         rd_ready_r;
  data_t        resp_data_n;
  logic         resp_valid_n;
  logic         resp_ready_n;
  desc_t        out_desc_n;
  logic         out_desc_valid_n;
  logic         out_desc_ready_n;
  bc_msg_t      bc_msg_out_n;
  logic         bc_msg_out_valid_n;
  logic         bc_msg_out_ready_n;

  ////////////////////////////////////////////////////////////
  // Input registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    rst_r                  <= rst;
    core_reset_r           <= core_reset;
    in_desc_r              <= in_desc;
    bc_msg_in_r            <= bc_msg_in;
    intercon_status_data_r <= intercon_status_data;
    intercon_status_addr_r <= intercon_status_addr;
  end

  // Strobes held low through reset
  always_ff @(posedge clk) begin
    if (rst) begin
      in_desc_valid_r   <= 1'b0;
      bc_msg_in_valid_r <= 1'b0;
    end else begin
      in_desc_valid_r   <= in_desc_valid;
      bc_msg_in_valid_r <= bc_msg_in_valid;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stream slices
  ////////////////////////////////////////////////////////////

  assign wr_beat = '{addr: dma_cmd_wr_addr, data: dma_cmd_wr_data, strb: dma_cmd_wr_strb};

  boundary_slice #(.payload_t(dma_wr_t)) wr_cmd_slice (
    .clk(clk), .rst(rst_r),
    .in_data(wr_beat), .in_valid(dma_cmd_wr_en), .in_ready(dma_cmd_wr_ready),
    .out_data(wr_beat_r), .out_valid(wr_en_r), .out_ready(wr_ready_r)
  );

  boundary_slice #(.payload_t(dma_addr_t)) rd_cmd_slice (
    .clk(clk), .rst(rst_r),
    .in_data(dma_cmd_rd_addr), .in_valid(dma_cmd_rd_en), .in_ready(dma_cmd_rd_ready),
    .out_data(rd_addr_r), .out_valid(rd_en_r), .out_ready(rd_ready_r)
  );

  boundary_slice #(.payload_t(data_t)) rd_resp_slice (
    .clk(clk), .rst(rst_r),
    .in_data(resp_data_n), .in_valid(resp_valid_n), .in_ready(resp_ready_n),
    .out_data(dma_rd_resp_data), .out_valid(dma_rd_resp_valid),
    .out_ready(dma_rd_resp_ready)
  );

  boundary_slice #(.payload_t(desc_t)) out_desc_slice (
    .clk(clk), .rst(rst_r),
    .in_data(out_desc_n), .in_valid(out_desc_valid_n), .in_ready(out_desc_ready_n),
    .out_data(out_desc), .out_valid(out_desc_valid), .out_ready(out_desc_ready)
  );

  boundary_slice #(.payload_t(bc_msg_t)) bc_out_slice (
    .clk(clk), .rst(rst_r),
    .in_data(bc_msg_out_n), .in_valid(bc_msg_out_valid_n), .in_ready(bc_msg_out_ready_n),
    .out_data(bc_msg_out), .out_valid(bc_msg_out_valid), .out_ready(bc_msg_out_ready)
  );

  ////////////////////////////////////////////////////////////
  // Core
  ////////////////////////////////////////////////////////////

  rpu_core rpu_core_inst (
    .clk(clk), .rst(rst_r), .core_reset(core_reset_r),
    .dma_cmd_wr_en(wr_en_r), .dma_cmd_wr_addr(wr_beat_r.addr),
    .dma_cmd_wr_data(wr_beat_r.data), .dma_cmd_wr_strb(wr_beat_r.strb),
    .dma_cmd_wr_ready(wr_ready_r),
    .dma_cmd_rd_en(rd_en_r), .dma_cmd_rd_addr(rd_addr_r), .dma_cmd_rd_ready(rd_ready_r),
    .dma_rd_resp_valid(resp_valid_n), .dma_rd_resp_data(resp_data_n),
    .dma_rd_resp_ready(resp_ready_n),
    .in_desc(in_desc_r), .in_desc_valid(in_desc_valid_r), .in_desc_taken(in_desc_taken),
    .out_desc(out_desc_n), .out_desc_valid(out_desc_valid_n),
    .out_desc_ready(out_desc_ready_n),
    .bc_msg_in(bc_msg_in_r), .bc_msg_in_valid(bc_msg_in_valid_r),
    .bc_msg_out(bc_msg_out_n), .bc_msg_out_valid(bc_msg_out_valid_n),
    .bc_msg_out_ready(bc_msg_out_ready_n),
    .intercon_status_data(intercon_status_data_r),
    .intercon_status_addr(intercon_status_addr_r),
    .rpu_status_data(rpu_status_data), .rpu_status_addr(rpu_status_addr)
  );

endmodule

//--- source/rpu_pkg.sv
// Shared RPU types for addresses, descriptors, broadcast messages and status, imported by RTL
`include "rpu_config.svh"

package rpu_pkg;

  typedef logic [`RPU_DATA_WIDTH-1:0]             data_t;
  typedef logic [`RPU_STRB_WIDTH-1:0]             strb_t;
  typedef logic [`RPU_DMA_ADDR_WIDTH-1:0]         dma_addr_t;
  typedef logic [$clog2(`RPU_PMEM_LINES)-1:0]     line_addr_t;
  typedef logic [$clog2(`RPU_STATUS_SLOTS)-1:0]   status_addr_t;
  typedef logic [3:0]                             port_t;

  // 64-bit descriptor, len in the top bits
  typedef struct packed {
    logic [15:0] len;
    logic [3:0]  slot;
    port_t       port;
    logic [7:0]  tag;
    logic [31:0] addr;
  } desc_t;

  // 47-bit broadcast message
  typedef struct packed {
    logic [31:0]                   data;
    logic [3:0]                    strb;
    logic [`RPU_BC_WORD_WIDTH-1:0] waddr;
  } bc_msg_t;

  // One DMA write beat, bundled for the boundary slice
  typedef struct packed {
    dma_addr_t addr;
    data_t     data;
    strb_t     strb;
  } dma_wr_t;

  // Line select sits just above the byte offset, upper bits ignored
  function automatic line_addr_t line_of(dma_addr_t addr);
    return addr[$clog2(`RPU_STRB_WIDTH) +: $bits(line_addr_t)];
  endfunction

endpackage

//--- source/rpu_status.sv
// Route register from the incoming status channel and event counters on the rotating output
`timescale 1ns/1ps
`include "rpu_config.svh"

module rpu_status import rpu_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic [31:0]  intercon_status_data,
  input  status_addr_t intercon_status_addr,
  input  logic         fwd_pulse,
  input  logic         wr_pulse,
  input  logic         rd_pulse,
  input  logic         bc_out_pulse,
  input  logic         bc_in_pulse,
  output port_t        route,
  output logic [31:0]  rpu_status_data,
  output status_addr_t rpu_status_addr
);

  logic [`RPU_STATUS_SLOTS-1:0] events;
  logic [31:0]                  cnt [`RPU_STATUS_SLOTS];
  status_addr_t                 next_addr;

  // Event per slot, unused slots stay zero
  always_comb begin
    events                = '0;
    events[`RPU_ST_FWD]    = fwd_pulse;
    events[`RPU_ST_WR]     = wr_pulse;
    events[`RPU_ST_RD]     = rd_pulse;
    events[`RPU_ST_BC_OUT] = bc_out_pulse;
    events[`RPU_ST_BC_IN]  = bc_in_pulse;
  end

  assign next_addr = rpu_status_addr + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      route           <= '0;
      rpu_status_addr <= '0;
      rpu_status_data <= '0;
      for (int i = 0; i < `RPU_STATUS_SLOTS; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      if (intercon_status_addr == status_addr_t'(`RPU_ST_ROUTE)) begin
        route <= intercon_status_data[$bits(port_t)-1:0];
      end
      // Counters wrap
      for (int i = 0; i < `RPU_STATUS_SLOTS; i++) begin
        if (events[i]) begin
          cnt[i] <= cnt[i] + 32'd1;
        end
      end
      // One slot per cycle
      rpu_status_addr <= next_addr;
      rpu_status_data <= (next_addr == status_addr_t'(`RPU_ST_ROUTE)) ? 32'(route)
                                                                     : cnt[next_addr];
    end
  end

endmodule
